/* sources.f */
rtl/epdc_pkg.sv
rtl/csr_pkg.sv
rtl/spi_csr.sv
rtl/epd_scan.sv
rtl/pixel_lut.sv
rtl/epdc_top.sv
verif/epdc_checker.sv
verif/epdc_tb.sv

/* Bender.yml */
package:
  name: epdc

sources:
  - files:
      - rtl/epdc_pkg.sv
      - rtl/csr_pkg.sv
      - rtl/spi_csr.sv
      - rtl/epd_scan.sv
      - rtl/pixel_lut.sv
      - rtl/epdc_top.sv
  - target: simulation
    files:
      - verif/epdc_checker.sv
      - verif/epdc_tb.sv

/* verif/epdc_tb.sv */
`timescale 1ns/1ps

module epdc_tb;
    import epdc_pkg::*;
    import csr_pkg::*;

    // Small panel so that a frame is a few dozen cycles
    localparam int unsigned H_ACTIVE = 4;
    localparam int unsigned H_BLANK  = 3;
    localparam int unsigned V_ACTIVE = 3;
    localparam int unsigned V_BLANK  = 1;

    // One table pass fills exactly one frame
    localparam int TABLE_LEN       = V_ACTIVE * H_ACTIVE;
    localparam int NUM_FIXED       = 6;
    localparam int FRAME_CYCLES    = (V_ACTIVE + V_BLANK) * (H_ACTIVE + H_BLANK);
    localparam int SPI_HALF        = 8;
    localparam int SPI_XFERS       = 16;
    localparam int SPI_XFER_CYCLES = 2 * SPI_HALF * (SPI_FRAME_BITS + 2);
    localparam int WATCHDOG_CYCLES = TABLE_LEN * FRAME_CYCLES * 4
                                     + SPI_XFERS * SPI_XFER_CYCLES;

    logic      clk_epdc = 1'b0;
    logic      arst_n;
    logic      spi_cs;
    logic      spi_sck;
    logic      spi_mosi;
    logic      spi_miso;
    logic      sys_ready;
    pix_word_t vin_pixel;
    logic      vin_valid;
    logic      vin_ready;
    pix_word_t bi_pixel;
    logic      bi_valid;
    logic      bi_ready;
    pix_word_t bo_pixel;
    logic      bo_valid;
    logic      b_trigger;
    logic      global_en;
    logic      epd_gdoe;
    logic      epd_gdclk;
    logic      epd_gdsp;
    logic      epd_sdclk;
    logic      epd_sdle;
    logic      epd_sdoe;
    sd_word_t  epd_sd;
    logic      epd_sdce0;

    // Stimulus table
    string     table_name [TABLE_LEN];
    pix_word_t tgt_tab    [TABLE_LEN];
    pix_word_t cur_tab    [TABLE_LEN];

    int   errors       = 0;
    int   tests_run    = 0;
    int   tests_failed = 0;
    int   words_seen   = 0;
    int   sdclk_cnt    = 0;
    int   sdle_cnt     = 0;
    int   gdclk_cnt    = 0;
    int   gdsp_cnt     = 0;
    int   trig_cnt     = 0;
    int   frames_done  = 0;
    int   snap_sdclk;
    int   snap_sdle;
    int   snap_gdclk;
    int   snap_gdsp;
    int   snap_trig;
    logic gdclk_prev   = 1'b0;
    logic oe_prev      = 1'b0;
    logic took         = 1'b0;

    epdc_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_BLANK  (H_BLANK),
        .V_ACTIVE (V_ACTIVE),
        .V_BLANK  (V_BLANK)
    ) epdc_top_i (
        .clk_epdc  (clk_epdc),
        .arst_n    (arst_n),
        .spi_cs    (spi_cs),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .sys_ready (sys_ready),
        .vin_pixel (vin_pixel),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .bi_pixel  (bi_pixel),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid),
        .b_trigger (b_trigger),
        .global_en (global_en),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sd    (epd_sd),
        .epd_sdce0 (epd_sdce0)
    );

    always #10 clk_epdc = ~clk_epdc;

    // Drive code per lane, one level step toward the target
    function automatic sd_word_t expected_drive(input pix_word_t tgt, input pix_word_t cur);
        sd_word_t sd;
        pix_t     t;
        pix_t     c;
        sd = '0;
        for (int k = 0; k < PIX_PER_WORD; k++) begin
            t = tgt[k*PIX_BITS +: PIX_BITS];
            c = cur[k*PIX_BITS +: PIX_BITS];
            if (c < t) begin
                sd[2*k +: 2] = DRV_LIGHT;
            end else if (c > t) begin
                sd[2*k +: 2] = DRV_DARK;
            end
        end
        return sd;
    endfunction

    function automatic pix_word_t next_state(input pix_word_t tgt, input pix_word_t cur);
        pix_word_t st;
        pix_t      t;
        pix_t      c;
        st = cur;
        for (int k = 0; k < PIX_PER_WORD; k++) begin
            t = tgt[k*PIX_BITS +: PIX_BITS];
            c = cur[k*PIX_BITS +: PIX_BITS];
            if (c < t) begin
                st[k*PIX_BITS +: PIX_BITS] = c + 1'b1;
            end else if (c > t) begin
                st[k*PIX_BITS +: PIX_BITS] = c - 1'b1;
            end
        end
        return st;
    endfunction

    task automatic verify_drive(input string name, input sd_word_t exp, input sd_word_t act,
                                inout bit ok);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic verify_state(input string name, input pix_word_t exp, input pix_word_t act,
                                inout bit ok);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic compare_reg(input string name, input csr_data_t exp, input csr_data_t act,
                               inout bit ok);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic expect_flag(input string name, input logic exp, input logic act,
                               inout bit ok);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic expect_count(input string name, input int exp, input int act, inout bit ok);
        if (act != exp) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input bit ok);
        tests_run++;
        if (ok) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s had errors", name);
        end
    endtask

    // Mode 0, MSB first; MISO read just before each rising sck
    task automatic spi_transfer(input bit wr, input csr_addr_t addr, input csr_data_t wdata,
                                output csr_data_t rdata);
        logic [SPI_FRAME_BITS-1:0] frame;
        frame = {wr, addr, wdata};
        rdata = '0;
        spi_cs = 1'b0;
        for (int i = SPI_FRAME_BITS - 1; i >= 0; i--) begin
            spi_mosi = frame[i];
            repeat (SPI_HALF) @(negedge clk_epdc);
            if (i < $bits(csr_data_t)) begin
                rdata[i] = spi_miso;
            end
            spi_sck = 1'b1;
            repeat (SPI_HALF) @(negedge clk_epdc);
            spi_sck = 1'b0;
        end
        repeat (SPI_HALF) @(negedge clk_epdc);
        spi_cs = 1'b1;
        repeat (SPI_HALF) @(negedge clk_epdc);
    endtask

    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        csr_data_t unused;
        spi_transfer(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input csr_addr_t addr, output csr_data_t data);
        spi_transfer(1'b0, addr, '0, data);
    endtask

    task automatic build_table();
        table_name[0] = "all_equal";
        tgt_tab[0]    = 32'h7654_3210;
        cur_tab[0]    = 32'h7654_3210;
        table_name[1] = "all_up_from_0";
        tgt_tab[1]    = 32'h1234_5678;
        cur_tab[1]    = 32'h0000_0000;
        table_name[2] = "all_down_from_15";
        tgt_tab[2]    = 32'h0123_4567;
        cur_tab[2]    = 32'hFFFF_FFFF;
        table_name[3] = "mixed_lanes";
        tgt_tab[3]    = 32'h5A5A_3C3C;
        cur_tab[3]    = 32'h5577_4C2C;
        table_name[4] = "lanes_0_to_15";
        tgt_tab[4]    = 32'hF0F0_F0F0;
        cur_tab[4]    = 32'h0F0F_0F0F;
        table_name[5] = "lanes_15_to_0";
        tgt_tab[5]    = 32'h0F0F_0F0F;
        cur_tab[5]    = 32'hF0F0_F0F0;
        for (int i = NUM_FIXED; i < TABLE_LEN; i++) begin
            table_name[i] = $sformatf("random_%0d", i - NUM_FIXED);
            tgt_tab[i]    = $urandom;
            cur_tab[i]    = $urandom;
        end
    endtask

    // Present every table word; gaps keep at least one stream invalid
    task automatic feed_table(input bit stall);
        int gaps;
        int mode;
        for (int i = 0; i < TABLE_LEN; i++) begin
            gaps = stall ? $urandom_range(3) : 0;
            repeat (gaps) begin
                mode      = $urandom_range(2);
                vin_pixel = $urandom;
                bi_pixel  = $urandom;
                vin_valid = (mode == 1);
                bi_valid  = (mode == 0);
                @(negedge clk_epdc);
            end
            vin_pixel = tgt_tab[i];
            bi_pixel  = cur_tab[i];
            vin_valid = 1'b1;
            bi_valid  = 1'b1;
            do @(negedge clk_epdc); while (!took);
        end
        vin_valid = 1'b0;
        bi_valid  = 1'b0;
    endtask

    task automatic take_snapshot();
        snap_sdclk = sdclk_cnt;
        snap_sdle  = sdle_cnt;
        snap_gdclk = gdclk_cnt;
        snap_gdsp  = gdsp_cnt;
        snap_trig  = trig_cnt;
    endtask

    task automatic check_frame_shape(input string name, input int frame_no,
                                     input csr_data_t cnt_before);
        csr_data_t rd;
        bit        ok;
        int        n;
        ok = 1'b1;
        n  = 0;
        while (frames_done < frame_no && n < 4 * FRAME_CYCLES) begin
            @(negedge clk_epdc);
            n++;
        end
        if (frames_done < frame_no) begin
            $display("%s: frame %0d never dropped epd_gdoe", name, frame_no);
            errors++;
            ok = 1'b0;
        end
        expect_flag({name, " sdoe after frame"}, 1'b0, epd_sdoe, ok);
        expect_flag({name, " sdce0 after frame"}, 1'b1, epd_sdce0, ok);
        expect_count({name, " sdclk pulses"}, V_ACTIVE * H_ACTIVE, sdclk_cnt - snap_sdclk, ok);
        expect_count({name, " sdle pulses"}, V_ACTIVE, sdle_cnt - snap_sdle, ok);
        expect_count({name, " gdclk toggles"}, V_ACTIVE, gdclk_cnt - snap_gdclk, ok);
        expect_count({name, " gdsp pulses"}, 1, gdsp_cnt - snap_gdsp, ok);
        expect_count({name, " b_trigger pulses"}, 1, trig_cnt - snap_trig, ok);
        read_reg(REG_FRAME_CNT, rd);
        compare_reg({name, " frame count"}, csr_data_t'(cnt_before + 1), rd, ok);
        finish_test(name, ok);
    endtask

    task automatic check_trigger_ignored(input string name);
        bit ok;
        ok = 1'b1;
        take_snapshot();
        write_reg(REG_TRIGGER, 8'h01);
        repeat (10) @(negedge clk_epdc);
        expect_count({name, " b_trigger pulses"}, 0, trig_cnt - snap_trig, ok);
        expect_count({name, " gdsp pulses"}, 0, gdsp_cnt - snap_gdsp, ok);
        finish_test(name, ok);
    endtask

    // Ready as seen by the last rising edge, read back on the falling edge
    always @(posedge clk_epdc) begin
        took <= vin_ready && bi_ready;
    end

    // Panel strobe counters
    always @(negedge clk_epdc) begin
        if (epd_sdclk) sdclk_cnt++;
        if (epd_sdle) sdle_cnt++;
        if (epd_gdsp) gdsp_cnt++;
        if (b_trigger) trig_cnt++;
        if (epd_gdclk !== gdclk_prev) gdclk_cnt++;
        if (oe_prev && !epd_gdoe) frames_done++;
        gdclk_prev = epd_gdclk;
        oe_prev    = epd_gdoe;
    end

    // Output words come back in table order, first pass steady, second with stalls
    always @(negedge clk_epdc) begin
        int    idx;
        string name;
        bit    ok;
        if (epd_sdclk || bo_valid) begin
            if (words_seen >= 2 * TABLE_LEN) begin
                $display("an extra word appeared on the source bus after the last table entry");
                errors++;
            end else begin
                idx  = words_seen % TABLE_LEN;
                name = $sformatf("%s_%s", (words_seen < TABLE_LEN) ? "steady" : "stall",
                                 table_name[idx]);
                ok   = 1'b1;
                verify_drive({name, " epd_sd"}, expected_drive(tgt_tab[idx], cur_tab[idx]),
                             epd_sd, ok);
                verify_state({name, " bo_pixel"}, next_state(tgt_tab[idx], cur_tab[idx]),
                             bo_pixel, ok);
                expect_flag({name, " epd_sdce0"}, 1'b0, epd_sdce0, ok);
                if (!(epd_sdclk && bo_valid)) begin
                    $display("%s: epd_sdclk and bo_valid did not pulse together", name);
                    errors++;
                    ok = 1'b0;
                end
                finish_test(name, ok);
            end
            words_seen++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_epdc);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        csr_data_t rd;
        csr_data_t cnt_before;
        bit        ok;
        void'($urandom(48078));
        arst_n     = 1'b0;
        spi_cs     = 1'b1;
        spi_sck    = 1'b0;
        spi_mosi   = 1'b0;
        sys_ready  = 1'b0;
        vin_pixel  = '0;
        vin_valid  = 1'b0;
        bi_pixel   = '0;
        bi_valid   = 1'b0;
        repeat (2) @(negedge clk_epdc);
        arst_n = 1'b1;
        build_table();
        @(negedge clk_epdc);

        ok = 1'b1;
        read_reg(REG_ID, rd);
        compare_reg("reg_id", CSR_ID_VALUE, rd, ok);
        finish_test("reg_id", ok);

        ok = 1'b1;
        write_reg(REG_CTRL, 8'h5A);
        read_reg(REG_CTRL, rd);
        compare_reg("reg_ctrl_readback", 8'h5A, rd, ok);
        finish_test("reg_ctrl_readback", ok);

        ok = 1'b1;
        sys_ready = 1'b1;
        read_reg(REG_STATUS, rd);
        compare_reg("reg_status_ready_high", 8'h02, rd, ok);
        sys_ready = 1'b0;
        read_reg(REG_STATUS, rd);
        compare_reg("reg_status_ready_low", 8'h00, rd, ok);
        finish_test("reg_status_ready", ok);

        // Trigger gating, global enable follows the control bit
        ok = 1'b1;
        write_reg(REG_CTRL, 8'h00);
        expect_flag("global_en_clear", 1'b0, global_en, ok);
        sys_ready = 1'b1;
        check_trigger_ignored("trigger_en_clear");
        write_reg(REG_CTRL, 8'h01);
        expect_flag("global_en_set", 1'b1, global_en, ok);
        finish_test("global_en", ok);
        sys_ready = 1'b0;
        check_trigger_ignored("trigger_not_ready");

        // First frame waits on empty streams while status is read
        sys_ready = 1'b1;
        read_reg(REG_FRAME_CNT, cnt_before);
        take_snapshot();
        write_reg(REG_TRIGGER, 8'h01);
        ok = 1'b1;
        read_reg(REG_STATUS, rd);
        compare_reg("reg_status_busy", 8'h03, rd, ok);
        finish_test("reg_status_busy", ok);
        feed_table(1'b0);
        check_frame_shape("frame_shape_steady", 1, cnt_before);

        // Second frame with random gaps on both streams
        read_reg(REG_FRAME_CNT, cnt_before);
        take_snapshot();
        fork
            feed_table(1'b1);
            write_reg(REG_TRIGGER, 8'h01);
        join
        check_frame_shape("frame_shape_stall", 2, cnt_before);

        repeat (5) @(negedge clk_epdc);
        ok = 1'b1;
        expect_count("words_written_back", 2 * TABLE_LEN, words_seen, ok);
        finish_test("words_written_back", ok);

        $display("summary: %0d tests run, %0d tests failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/epdc_checker.sv */
`timescale 1ns/1ps

module epdc_checker (
    input logic clk_epdc,
    input logic arst_n,
    input logic epd_sdclk,
    input logic epd_sdoe,
    input logic bo_valid,
    input logic vin_ready,
    input logic vin_valid,
    input logic bi_valid,
    input logic epd_gdsp,
    input logic b_trigger
);

    // Source clock stays inside the output enable window
    sdclk_in_window: assert property (@(posedge clk_epdc) disable iff (!arst_n)
        epd_sdclk |-> epd_sdoe)
        else $error("epd_sdclk pulsed while epd_sdoe was low");

    // Write-back and source clock are one strobe
    bo_with_sdclk: assert property (@(posedge clk_epdc) disable iff (!arst_n)
        bo_valid == epd_sdclk)
        else $error("bo_valid and epd_sdclk differ");

    ready_needs_both: assert property (@(posedge clk_epdc) disable iff (!arst_n)
        vin_ready |-> (vin_valid && bi_valid))
        else $error("vin_ready high without both input streams valid");

    // Gate start pulse only right after an accepted trigger
    gdsp_after_trigger: assert property (@(posedge clk_epdc) disable iff (!arst_n)
        epd_gdsp |-> $past(b_trigger))
        else $error("epd_gdsp without a trigger one cycle before");

    trigger_starts_gate: assert property (@(posedge clk_epdc) disable iff (!arst_n)
        b_trigger |=> epd_gdsp)
        else $error("accepted trigger not followed by epd_gdsp");

endmodule

bind epdc_top epdc_checker epdc_checker_i (
    .clk_epdc  (clk_epdc),
    .arst_n    (arst_n),
    .epd_sdclk (epd_sdclk),
    .epd_sdoe  (epd_sdoe),
    .bo_valid  (bo_valid),
    .vin_ready (vin_ready),
    .vin_valid (vin_valid),
    .bi_valid  (bi_valid),
    .epd_gdsp  (epd_gdsp),
    .b_trigger (b_trigger)
);

/* rtl/epdc_top.sv */
`timescale 1ns/1ps

module epdc_top #(
    parameter int unsigned H_ACTIVE = 100,
    parameter int unsigned H_BLANK  = 8,
    parameter int unsigned V_ACTIVE = 600,
    parameter int unsigned V_BLANK  = 4
) (
    input  logic                clk_epdc,
    input  logic                arst_n,
    // SPI register port
    input  logic                spi_cs,
    input  logic                spi_sck,
    input  logic                spi_mosi,
    output logic                spi_miso,
    input  logic                sys_ready,
    // Target levels and framebuffer streams
    input  epdc_pkg::pix_word_t vin_pixel,
    input  logic                vin_valid,
    output logic                vin_ready,
    input  epdc_pkg::pix_word_t bi_pixel,
    input  logic                bi_valid,
    output logic                bi_ready,
    output epdc_pkg::pix_word_t bo_pixel,
    output logic                bo_valid,
    // Control
    output logic                b_trigger,
    output logic                global_en,
    // Panel
    output logic                epd_gdoe,
    output logic                epd_gdclk,
    output logic                epd_gdsp,
    output logic                epd_sdclk,
    output logic                epd_sdle,
    output logic                epd_sdoe,
    output epdc_pkg::sd_word_t  epd_sd,
    output logic                epd_sdce0
);
    logic busy;
    logic frame_done;
    logic take;

    // Accepted trigger starts the scanner directly
    spi_csr spi_csr_i (
        .clk_epdc    (clk_epdc),
        .arst_n      (arst_n),
        .spi_cs      (spi_cs),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .sys_ready   (sys_ready),
        .busy        (busy),
        .frame_done  (frame_done),
        .global_en   (global_en),
        .frame_start (b_trigger)
    );

    epd_scan #(
        .H_ACTIVE (H_ACTIVE),
        .H_BLANK  (H_BLANK),
        .V_ACTIVE (V_ACTIVE),
        .V_BLANK  (V_BLANK)
    ) epd_scan_i (
        .clk_epdc    (clk_epdc),
        .arst_n      (arst_n),
        .frame_start (b_trigger),
        .vin_valid   (vin_valid),
        .bi_valid    (bi_valid),
        .vin_ready   (vin_ready),
        .bi_ready    (bi_ready),
        .take        (take),
        .busy        (busy),
        .frame_done  (frame_done),
        .epd_gdsp    (epd_gdsp),
        .epd_gdclk   (epd_gdclk),
        .epd_gdoe    (epd_gdoe),
        .epd_sdle    (epd_sdle),
        .epd_sdoe    (epd_sdoe),
        .epd_sdce0   (epd_sdce0)
    );

    pixel_lut pixel_lut_i (
        .clk_epdc  (clk_epdc),
        .arst_n    (arst_n),
        .take      (take),
        .vin_pixel (vin_pixel),
        .bi_pixel  (bi_pixel),
        .epd_sd    (epd_sd),
        .epd_sdclk (epd_sdclk),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid)
    );

endmodule

/* rtl/pixel_lut.sv */
`timescale 1ns/1ps

module pixel_lut (
    input  logic                clk_epdc,
    input  logic                arst_n,
    input  logic                take,
    input  epdc_pkg::pix_word_t vin_pixel,
    input  epdc_pkg::pix_word_t bi_pixel,
    output epdc_pkg::sd_word_t  epd_sd,
    output logic                epd_sdclk,
    output epdc_pkg::pix_word_t bo_pixel,
    output logic                bo_valid
);
    import epdc_pkg::*;

    sd_word_t  sd_next;
    pix_word_t state_next;
    logic      word_vld;

    // Each lane moves the pixel one level toward its target
    for (genvar k = 0; k < PIX_PER_WORD; k++) begin : g_lane
        pix_t   tgt;
        pix_t   cur;
        pix_t   nxt;
        drive_t drv;

        assign tgt = vin_pixel[k*PIX_BITS +: PIX_BITS];
        assign cur = bi_pixel[k*PIX_BITS +: PIX_BITS];

        always_comb begin
            if (cur < tgt) begin
                drv = DRV_LIGHT;
                nxt = cur + 1'b1;
            end else if (cur > tgt) begin
                drv = DRV_DARK;
                nxt = cur - 1'b1;
            end else begin
                drv = DRV_NONE;
                nxt = cur;
            end
        end

        assign sd_next[k*DRV_BITS +: DRV_BITS]    = drv;
        assign state_next[k*PIX_BITS +: PIX_BITS] = nxt;
    end

    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            word_vld <= 1'b0;
        end else begin
            word_vld <= take;
        end
    end

    always_ff @(posedge clk_epdc) begin
        if (take) begin
            epd_sd   <= sd_next;
            bo_pixel <= state_next;
        end
    end

    // Source clock and write-back share one strobe
    assign epd_sdclk = word_vld;
    assign bo_valid  = word_vld;

endmodule

/* rtl/epd_scan.sv */
`timescale 1ns/1ps

module epd_scan #(
    parameter int unsigned H_ACTIVE = 100,
    parameter int unsigned H_BLANK  = 8,
    parameter int unsigned V_ACTIVE = 600,
    parameter int unsigned V_BLANK  = 4
) (
    input  logic clk_epdc,
    input  logic arst_n,
    input  logic frame_start,
    input  logic vin_valid,
    input  logic bi_valid,
    output logic vin_ready,
    output logic bi_ready,
    output logic take,
    output logic busy,
    output logic frame_done,
    output logic epd_gdsp,
    output logic epd_gdclk,
    output logic epd_gdoe,
    output logic epd_sdle,
    output logic epd_sdoe,
    output logic epd_sdce0
);
    // Horizontal counter also spans a whole blank line
    localparam int H_W = $clog2(H_ACTIVE + H_BLANK + 1);
    localparam int V_W = $clog2(V_ACTIVE + V_BLANK + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LINE,
        S_HBLANK,
        S_VBLANK
    } state_t;

    state_t         state;
    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           oe_q;
    logic           line_end_q;
    logic           last_word;
    logic           hblank_end;
    logic           vblank_line_end;
    logic           last_line;
    logic           last_vblank;

    assign last_word       = h_cnt == H_W'(H_ACTIVE - 1);
    assign hblank_end      = h_cnt == H_W'(H_BLANK - 1);
    assign vblank_line_end = h_cnt == H_W'(H_ACTIVE + H_BLANK - 1);
    assign last_line       = v_cnt == V_W'(V_ACTIVE - 1);
    assign last_vblank     = v_cnt == V_W'(V_BLANK - 1);

    // A slot only advances when both streams have a word
    assign take      = (state == S_LINE) && vin_valid && bi_valid;
    assign vin_ready = take;
    assign bi_ready  = take;

    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            h_cnt      <= '0;
            v_cnt      <= '0;
            oe_q       <= 1'b0;
            epd_gdsp   <= 1'b0;
            epd_gdclk  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            epd_gdsp   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (frame_start) begin
                        state     <= S_LINE;
                        h_cnt     <= '0;
                        v_cnt     <= '0;
                        oe_q      <= 1'b1;
                        epd_gdsp  <= 1'b1;
                        epd_gdclk <= !epd_gdclk;
                    end
                end
                S_LINE: begin
                    if (take) begin
                        if (last_word) begin
                            h_cnt <= '0;
                            state <= S_HBLANK;
                        end else begin
                            h_cnt <= h_cnt + 1'b1;
                        end
                    end
                end
                S_HBLANK: begin
                    if (!hblank_end) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        if (!last_line) begin
                            v_cnt     <= v_cnt + 1'b1;
                            state     <= S_LINE;
                            epd_gdclk <= !epd_gdclk;
                        end else if (V_BLANK == 0) begin
                            state      <= S_IDLE;
                            oe_q       <= 1'b0;
                            frame_done <= 1'b1;
                        end else begin
                            v_cnt <= '0;
                            state <= S_VBLANK;
                        end
                    end
                end
                S_VBLANK: begin
                    if (!vblank_line_end) begin
                        h_cnt <= h_cnt + 1'b1;
                    end else begin
                        h_cnt <= '0;
                        if (last_vblank) begin
                            state      <= S_IDLE;
                            oe_q       <= 1'b0;
                            frame_done <= 1'b1;
                        end else begin
                            v_cnt <= v_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Strobes follow the registered pixel stage by one cycle
    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            line_end_q <= 1'b0;
            epd_sdle   <= 1'b0;
            epd_sdce0  <= 1'b1;
        end else begin
            line_end_q <= take && last_word;
            epd_sdle   <= line_end_q;
            epd_sdce0  <= state != S_LINE;
        end
    end

    assign busy     = oe_q;
    assign epd_gdoe = oe_q;
    assign epd_sdoe = oe_q;

endmodule

/* rtl/spi_csr.sv */
`timescale 1ns/1ps

module spi_csr (
    input  logic clk_epdc,
    input  logic arst_n,
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso,
    input  logic sys_ready,
    input  logic busy,
    input  logic frame_done,
    output logic global_en,
    output logic frame_start
);
    import csr_pkg::*;

    localparam int CNT_W = $clog2(SPI_FRAME_BITS);

    logic [1:0]                cs_sync;
    logic [1:0]                sck_sync;
    logic [1:0]                mosi_sync;
    logic                      sck_prev;
    logic                      selected;
    logic                      sck_rise;
    logic                      sck_fall;
    logic [CNT_W-1:0]          bit_cnt;
    logic [SPI_FRAME_BITS-2:0] shift_q;
    logic [SPI_FRAME_BITS-1:0] frame_next;
    logic                      frame_wr;
    csr_addr_t                 wr_addr;
    csr_data_t                 wr_data;
    csr_addr_t                 rd_addr;
    csr_data_t                 rd_data;
    csr_data_t                 ctrl_q;
    csr_data_t                 frame_cnt_q;
    csr_data_t                 miso_sh;
    logic                      rd_active;

    // Two-flop synchronizers, chip deselected at reset
    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            cs_sync   <= 2'b11;
            sck_sync  <= 2'b00;
            mosi_sync <= 2'b00;
            sck_prev  <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs};
            sck_sync  <= {sck_sync[0], spi_sck};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sck_prev  <= sck_sync[1];
        end
    end

    assign selected = !cs_sync[1];
    assign sck_rise = selected && sck_sync[1] && !sck_prev;
    assign sck_fall = selected && !sck_sync[1] && sck_prev;

    // Frame as it stands once the current bit is shifted in
    assign frame_next = {shift_q, mosi_sync[1]};
    assign frame_wr   = sck_rise && (bit_cnt == CNT_W'(SPI_FRAME_BITS - 1))
                        && frame_next[SPI_WR_BIT];
    assign wr_addr    = frame_next[SPI_ADDR_LSB +: $bits(csr_addr_t)];
    assign wr_data    = frame_next[$bits(csr_data_t)-1:0];

    // After the header bits the address sits at the bottom of the shifter
    assign rd_addr    = shift_q[$bits(csr_addr_t)-1:0];

    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
        end else if (!selected) begin
            bit_cnt <= '0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_epdc) begin
        if (sck_rise) begin
            shift_q <= frame_next[SPI_FRAME_BITS-2:0];
        end
    end

    // Register writes and trigger acceptance
    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q      <= '0;
            frame_cnt_q <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (frame_wr) begin
                case (wr_addr)
                    REG_CTRL:    ctrl_q <= wr_data;
                    REG_TRIGGER: frame_start <= ctrl_q[CTRL_EN] && sys_ready && !busy;
                    default:     ;
                endcase
            end
            if (frame_done) begin
                frame_cnt_q <= frame_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (rd_addr)
            REG_CTRL:      rd_data = ctrl_q;
            REG_STATUS: begin
                rd_data[STAT_BUSY]  = busy;
                rd_data[STAT_READY] = sys_ready;
            end
            REG_FRAME_CNT: rd_data = frame_cnt_q;
            REG_ID:        rd_data = CSR_ID_VALUE;
            default:       rd_data = '0;
        endcase
    end

    // Read data goes out on falling sck, first bit right after the header
    always_ff @(posedge clk_epdc or negedge arst_n) begin
        if (!arst_n) begin
            spi_miso  <= 1'b1;
            miso_sh   <= '1;
            rd_active <= 1'b0;
        end else if (!selected) begin
            spi_miso  <= 1'b1;
            rd_active <= 1'b0;
        end else if (sck_fall) begin
            if (bit_cnt == CNT_W'(SPI_ADDR_LSB)) begin
                rd_active <= !shift_q[SPI_WR_BIT - SPI_ADDR_LSB];
                if (!shift_q[SPI_WR_BIT - SPI_ADDR_LSB]) begin
                    spi_miso <= rd_data[$bits(csr_data_t)-1];
                    miso_sh  <= {rd_data[$bits(csr_data_t)-2:0], 1'b1};
                end
            end else if (rd_active) begin
                spi_miso <= miso_sh[$bits(csr_data_t)-1];
                miso_sh  <= {miso_sh[$bits(csr_data_t)-2:0], 1'b1};
            end
        end
    end

    assign global_en = ctrl_q[CTRL_EN];

endmodule

/* rtl/csr_pkg.sv */
package csr_pkg;

    typedef logic [6:0] csr_addr_t;
    typedef logic [7:0] csr_data_t;

    // Register map
    localparam csr_addr_t REG_CTRL      = 7'h00;
    localparam csr_addr_t REG_TRIGGER   = 7'h01;
    localparam csr_addr_t REG_STATUS    = 7'h02;
    localparam csr_addr_t REG_FRAME_CNT = 7'h03;
    localparam csr_addr_t REG_ID        = 7'h0F;

    // Control and status bits
    localparam int CTRL_EN    = 0;
    localparam int STAT_BUSY  = 0;
    localparam int STAT_READY = 1;

    localparam csr_data_t CSR_ID_VALUE = 8'hE5;

    // SPI frame is write flag, 7-bit address, 8-bit data
    localparam int SPI_FRAME_BITS = 16;
    localparam int SPI_WR_BIT     = 15;
    localparam int SPI_ADDR_LSB   = 8;

endpackage

/* rtl/epdc_pkg.sv */
package epdc_pkg;

    // Pixel geometry of the panel datapath
    localparam int PIX_BITS     = 4;
    localparam int PIX_PER_WORD = 8;

    // One stream word carries a full group of pixels
    localparam int WORD_BITS    = PIX_BITS * PIX_PER_WORD;

    // Source driver takes 2 bits per pixel
    localparam int DRV_BITS     = 2;
    localparam int SD_BITS      = DRV_BITS * PIX_PER_WORD;

    // Single pixel level or state
    typedef logic [PIX_BITS-1:0] pix_t;

    // One-step drive code sent to the source driver
    typedef enum logic [DRV_BITS-1:0] {
        DRV_NONE  = 2'd0,
        DRV_DARK  = 2'd1,
        DRV_LIGHT = 2'd2
    } drive_t;

    // Stream word, lane k in bits 4k+3 down to 4k
    typedef logic [WORD_BITS-1:0] pix_word_t;

    // Source data bus, lane k in bits 2k+1 down to 2k
    typedef logic [SD_BITS-1:0] sd_word_t;

endpackage
